// File: iconnect.f
verilog/iconnect_pkg.sv
verilog/dmem_core_port.sv
verilog/dmem_arbiter.sv
verilog/dmem_timer.sv
verilog/dual_core_iconnect.sv
bench/xbus_model.sv
bench/tb_iconnect.sv

// File: run_sim.sh
#!/bin/sh
# Build the dual-core interconnect testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_iconnect -f iconnect.f --Mdir obj_dir -o sim_iconnect
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/sim_iconnect 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1

// File: bench/tb_iconnect.sv
// Testbench for the dual-core interconnect; run through run_sim.sh with Verilator
`timescale 1ns/1ps
`default_nettype none

module tb_iconnect import iconnect_pkg::*; ();

   logic                  clk = 1'b0;
   logic                  arst_n;
   logic                  hold;                 // Stalls the bus model
   logic [1:0]            req_valid;
   dmem_req_t [1:0]       req;
   logic [1:0]            ack;
   dmem_rsp_t [1:0]       rsp;
   logic                  xbus_req_valid;
   dmem_req_t             xbus_req;
   logic                  xbus_rsp_valid;
   dmem_rsp_t             xbus_rsp;
   logic [63:0]           timer_val;
   logic                  timer_irq;

   // Copies taken at the rising edge, read at the falling edge
   logic [1:0]            ack_q;
   dmem_rsp_t [1:0]       rsp_q;
   logic                  irq_q;
   logic                  last1_q;              // Core 1 had the last ack
   logic                  last_vld_q;
   int                    inflight;             // Bus requests not yet answered

   dmem_rsp_t [1:0]       exp_rsp;              // Expected answer per core
   logic [1:0]            exp_chk;              // Compare read data too
   logic                  rst_chk;
   logic                  rr_chk;
   int                    err_cnt      = 0;
   int                    tests_run    = 0;
   int                    tests_failed = 0;
   logic [15:0]           lfsr_q       = 16'd45993;

   always #50 clk = ~clk;

   dual_core_iconnect dut (
      .core_clk_i        (clk           ),
      .arst_n_i          (arst_n        ),
      .core0_req_valid_i (req_valid[0]  ),
      .core0_req_i       (req[0]        ),
      .core0_req_ack_o   (ack[0]        ),
      .core0_rsp_o       (rsp[0]        ),
      .core1_req_valid_i (req_valid[1]  ),
      .core1_req_i       (req[1]        ),
      .core1_req_ack_o   (ack[1]        ),
      .core1_rsp_o       (rsp[1]        ),
      .xbus_req_valid_o  (xbus_req_valid),
      .xbus_req_o        (xbus_req      ),
      .xbus_rsp_valid_i  (xbus_rsp_valid),
      .xbus_rsp_i        (xbus_rsp      ),
      .timer_val_o       (timer_val     ),
      .timer_irq_o       (timer_irq     )
   );

   xbus_model u_xbus (
      .clk_i       (clk           ),
      .arst_n_i    (arst_n        ),
      .hold_i      (hold          ),
      .req_valid_i (xbus_req_valid),
      .req_i       (xbus_req      ),
      .rsp_valid_o (xbus_rsp_valid),
      .rsp_o       (xbus_rsp      )
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack_q      <= '0;
         rsp_q      <= '0;
         irq_q      <= 1'b0;
         last1_q    <= 1'b0;
         last_vld_q <= 1'b0;
         inflight   <= 0;
      end else begin
         ack_q    <= ack;
         rsp_q    <= rsp;
         irq_q    <= timer_irq;
         inflight <= inflight + int'(xbus_req_valid) - int'(xbus_rsp_valid);
         if (|ack) begin
            last1_q    <= ack[1];
            last_vld_q <= 1'b1;
         end
      end
   end

   // ---------------------------------------------------------------------
   // Assertions
   // ---------------------------------------------------------------------
   assert property (@(posedge clk) rst_chk |-> (ack == 2'b00) && !xbus_req_valid &&
      !timer_irq && (rsp[0].resp == DMEM_RESP_NOTRDY) && (rsp[1].resp == DMEM_RESP_NOTRDY))
   else begin
      err_cnt++;
      $display("ERROR core_req_ack_o %h xbus_req_valid_o %h timer_irq_o %h rsp %h %h at reset",
               $sampled(ack), $sampled(xbus_req_valid), $sampled(timer_irq),
               $sampled(rsp[0].resp), $sampled(rsp[1].resp));
   end

   // Never more bus requests open than credits
   assert property (@(posedge clk) disable iff (!arst_n) inflight <= XBUS_CREDITS)
   else begin
      err_cnt++;
      $display("ERROR xbus_req_valid_o in flight %h exp at most %h", $sampled(inflight),
               XBUS_CREDITS);
   end

   assert property (@(posedge clk) disable iff (!arst_n)
      (rr_chk && last_vld_q && (req_valid == 2'b11)) |-> (ack == {~last1_q, last1_q}))
   else begin
      err_cnt++;
      $display("ERROR core_req_ack_o %h exp %h", $sampled(ack),
               {~$sampled(last1_q), $sampled(last1_q)});
   end

   for (genvar g = 0; g < 2; g++) begin : g_core_chk
      // Any final code must match the open access
      assert property (@(posedge clk) disable iff (!arst_n)
         (rsp[g].resp != DMEM_RESP_NOTRDY) |-> (rsp[g].resp == exp_rsp[g].resp) &&
         (!exp_chk[g] || (rsp[g].rdata == exp_rsp[g].rdata)))
      else begin
         err_cnt++;
         $display("ERROR core%0d_rsp_o resp %h exp %h rdata %h exp %h", g,
                  $sampled(rsp[g].resp), $sampled(exp_rsp[g].resp),
                  $sampled(rsp[g].rdata), $sampled(exp_rsp[g].rdata));
      end

      assert property (@(posedge clk) disable iff (!arst_n)
         (ack[g] && (req[g].addr.bus.page == TIMER_PAGE)) |=> (rsp[g].resp != DMEM_RESP_NOTRDY))
      else begin
         err_cnt++;
         $display("Core %0d timer access had no answer in the cycle after its ack", g);
      end
   end

   // ---------------------------------------------------------------------
   // Helpers
   // ---------------------------------------------------------------------
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois taps 16,14,13,11
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] tmr_addr(input logic [5:0] idx);
      return {TIMER_PAGE, idx, 2'b00};
   endfunction

   function automatic logic [31:0] bus_addr(input logic [5:0] word);
      return {24'h00_0400, word, 2'b00};                   // Any page but the timer's
   endfunction

   // One access on core c, started and finished at a falling edge
   task automatic access(input logic c, input dmem_cmd_e cmd, input dmem_width_e width,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input dmem_resp_e exp_code, input logic chk,
                         input logic [31:0] exp_rdata, output logic [31:0] rdata);
      int n;
      exp_rsp[c].resp  = exp_code;
      exp_rsp[c].rdata = exp_rdata;
      exp_chk[c]       = chk;
      req[c].cmd       = cmd;
      req[c].width     = width;
      req[c].addr      = addr;
      req[c].wdata     = wdata;
      req_valid[c]     = 1'b1;
      rdata            = '0;
      n                = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ack_q[c] && (n < 200));
      req_valid[c] = 1'b0;                              // Nothing new until answered
      if (!ack_q[c]) begin
         err_cnt++;
         $display("Timeout: core %0d request not accepted within 200 cycles", c);
      end else begin
         n = 0;
         do begin
            @(negedge clk);
            n++;
         end while ((rsp_q[c].resp == DMEM_RESP_NOTRDY) && (n < 200));
         if (rsp_q[c].resp == DMEM_RESP_NOTRDY) begin
            err_cnt++;
            $display("Timeout: core %0d got no answer within 200 cycles", c);
         end else begin
            rdata = rsp_q[c].rdata;
         end
      end
   endtask

   task automatic report_test(input int num, input string name, input int mark);
      tests_run++;
      if (err_cnt == mark) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d error(s)", num, name, err_cnt - mark);
      end
   endtask

   // ---------------------------------------------------------------------
   // Stimulus
   // ---------------------------------------------------------------------
   initial begin
      logic [31:0] w0, w1, d0, d1, rd0, rd1, t1, t2, lo, hi, gap0, gap1;
      logic [63:0] cmp;
      logic [63:0] tv;
      int          mark;
      int          n;
      arst_n    = 1'b0;
      hold      = 1'b0;
      req_valid = '0;
      req       = '0;
      exp_rsp   = '0;
      exp_chk   = '0;
      rst_chk   = 1'b1;
      rr_chk    = 1'b0;

      // Test 1 keeps outputs quiet through reset
      mark = err_cnt;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      rst_chk = 1'b0;                                   // First cycle out of reset seen
      report_test(1, "reset state", mark);

      // Test 2 runs both cores at once through the tag queue
      mark = err_cnt;
      for (int r = 0; r < 4; r++) begin
         w0 = rand_bits(5);
         w1 = rand_bits(5);
         d0 = rand_bits(32);
         d1 = rand_bits(32);
         fork
            access(1'b0, DMEM_CMD_WR, DMEM_WIDTH_WORD, bus_addr({1'b0, w0[4:0]}), d0,
                   DMEM_RESP_RDY_OK, 1'b0, '0, rd0);
            access(1'b1, DMEM_CMD_WR, DMEM_WIDTH_WORD, bus_addr({1'b1, w1[4:0]}), d1,
                   DMEM_RESP_RDY_OK, 1'b0, '0, rd1);
         join
         fork
            access(1'b0, DMEM_CMD_RD, DMEM_WIDTH_WORD, bus_addr({1'b0, w0[4:0]}), '0,
                   DMEM_RESP_RDY_OK, 1'b1, d0, rd0);
            access(1'b1, DMEM_CMD_RD, DMEM_WIDTH_WORD, bus_addr({1'b1, w1[4:0]}), '0,
                   DMEM_RESP_RDY_OK, 1'b1, d1, rd1);
         join
      end
      report_test(2, "bus write and read back", mark);

      // Test 3 holds the bus while timer reads go through
      mark = err_cnt;
      d0   = rand_bits(32);
      d1   = rand_bits(32);
      hold = 1'b1;
      fork
         access(1'b0, DMEM_CMD_WR, DMEM_WIDTH_WORD, bus_addr(6'd3), d0,
                DMEM_RESP_RDY_OK, 1'b0, '0, rd0);
         begin
            access(1'b1, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CTRL), '0,
                   DMEM_RESP_RDY_OK, 1'b1, '0, rd1);
            access(1'b1, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CTRL), '0,
                   DMEM_RESP_RDY_OK, 1'b1, '0, rd1);
            access(1'b1, DMEM_CMD_WR, DMEM_WIDTH_WORD, bus_addr(6'd40), d1,
                   DMEM_RESP_RDY_OK, 1'b0, '0, rd1);
         end
         begin
            repeat (30) @(negedge clk);
            hold = 1'b0;                                // Let the bus drain
         end
      join
      report_test(3, "credit limit under hold", mark);

      // Test 4 enables the count and tries illegal accesses
      mark = err_cnt;
      access(1'b0, DMEM_CMD_WR, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CTRL), 32'd1,
             DMEM_RESP_RDY_OK, 1'b0, '0, rd0);
      access(1'b0, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_MTIME_LO), '0,
             DMEM_RESP_RDY_OK, 1'b0, '0, t1);
      access(1'b1, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_MTIME_LO), '0,
             DMEM_RESP_RDY_OK, 1'b0, '0, t2);
      assert (t2 > t1) else begin
         err_cnt++;
         $display("ERROR mtime_lo %h exp above %h", t2, t1);
      end
      tv = timer_val;                                   // One tick per core clock
      repeat (10) @(negedge clk);
      assert (timer_val == tv + 64'd10) else begin
         err_cnt++;
         $display("ERROR timer_val_o %h exp %h", timer_val, tv + 64'd10);
      end
      access(1'b0, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(6'd7), '0,
             DMEM_RESP_RDY_ER, 1'b0, '0, rd0);
      access(1'b1, DMEM_CMD_RD, DMEM_WIDTH_BYTE, tmr_addr(TMR_REG_CTRL), '0,
             DMEM_RESP_RDY_ER, 1'b0, '0, rd1);
      report_test(4, "timer count and errors", mark);

      // Test 5 drives the compare interrupt
      mark = err_cnt;
      access(1'b0, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_MTIME_LO), '0,
             DMEM_RESP_RDY_OK, 1'b0, '0, lo);
      access(1'b0, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_MTIME_HI), '0,
             DMEM_RESP_RDY_OK, 1'b0, '0, hi);
      cmp = {hi, lo} + 64'd20;
      access(1'b0, DMEM_CMD_WR, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CMP_HI), cmp[63:32],
             DMEM_RESP_RDY_OK, 1'b0, '0, rd0);          // High half first
      access(1'b0, DMEM_CMD_WR, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CMP_LO), cmp[31:0],
             DMEM_RESP_RDY_OK, 1'b0, '0, rd0);
      n = 0;
      while (!irq_q && (n < 100)) begin
         @(negedge clk);
         n++;
      end
      if (!irq_q) begin
         err_cnt++;
         $display("Timeout: timer_irq_o did not rise within 100 cycles");
      end
      access(1'b1, DMEM_CMD_WR, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CMP_HI), 32'hFFFF_FFFF,
             DMEM_RESP_RDY_OK, 1'b0, '0, rd1);
      assert (!irq_q) else begin
         err_cnt++;
         $display("ERROR timer_irq_o %h exp %h", irq_q, 1'b0);
      end
      report_test(5, "timer interrupt", mark);

      // Test 6 has both cores hammer the timer
      mark   = err_cnt;
      gap0   = rand_bits(8);
      gap1   = rand_bits(8);
      rr_chk = 1'b1;
      fork
         for (int k = 0; k < 8; k++) begin
            access(1'b0, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CTRL), '0,
                   DMEM_RESP_RDY_OK, 1'b1, 32'd1, rd0);
            if (gap0[k]) @(negedge clk);                // Idle cycle now and then
         end
         for (int k = 0; k < 8; k++) begin
            access(1'b1, DMEM_CMD_RD, DMEM_WIDTH_WORD, tmr_addr(TMR_REG_CTRL), '0,
                   DMEM_RESP_RDY_OK, 1'b1, 32'd1, rd1);
            if (gap1[k]) @(negedge clk);
         end
      join
      rr_chk = 1'b0;
      report_test(6, "round-robin on the timer", mark);

      repeat (3) @(negedge clk);
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule : tb_iconnect

`default_nettype wire

// File: bench/xbus_model.sv
// In-order external bus memory for the testbench, answers three cycles after each request
`timescale 1ns/1ps
`default_nettype none

module xbus_model import iconnect_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  logic      hold_i,              // Holds back every answer
   input  logic      req_valid_i,
   input  dmem_req_t req_i,
   output logic      rsp_valid_o,         // One per request, returns a credit
   output dmem_rsp_t rsp_o
);

   typedef struct packed {
      dmem_req_t   req;
      logic [31:0] due;                   // Cycle the answer may leave
   } pend_t;

   pend_t       pend_q [$];               // Open requests, oldest first
   pend_t       head;
   pend_t       entry;
   logic [31:0] mem [64];
   logic [31:0] cyc;
   logic [5:0]  widx;

   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_valid_o <= 1'b0;
         rsp_o       <= '0;
         cyc         <= '0;
         pend_q.delete();
         for (int i = 0; i < 64; i++) begin
            mem[6'(i)] <= {26'h1A5_5A5, 6'(i)};   // Fill tracks the word index
         end
      end else begin
         cyc         <= cyc + 32'd1;
         rsp_valid_o <= 1'b0;
         rsp_o       <= '{resp: DMEM_RESP_NOTRDY, rdata: '0};
         // Answer the oldest once it is due
         if (!hold_i && (pend_q.size() != 0) && (pend_q[0].due <= cyc)) begin
            head        = pend_q.pop_front();
            widx        = head.req.addr.bus.offset[7:2];
            rsp_valid_o <= 1'b1;
            rsp_o.resp  <= DMEM_RESP_RDY_OK;
            if (head.req.cmd == DMEM_CMD_WR) begin
               mem[widx] <= head.req.wdata;
            end else begin
               rsp_o.rdata <= mem[widx];
            end
         end
         if (req_valid_i) begin
            entry.req = req_i;
            entry.due = cyc + 32'd3;         // Three cycles of latency
            pend_q.push_back(entry);
         end
      end
   end

endmodule : xbus_model

`default_nettype wire

// File: verilog/dual_core_iconnect.sv
// Top level of the dual-core data interconnect joining core ports, arbiter and timer
`timescale 1ns/1ps
`default_nettype none

module dual_core_iconnect import iconnect_pkg::*; (
   input  logic        core_clk_i,         // Core clock, also the timer tick
   input  logic        arst_n_i,           // Async reset, active low

   // Core 0 data memory
   input  logic        core0_req_valid_i,
   input  dmem_req_t   core0_req_i,
   output logic        core0_req_ack_o,
   output dmem_rsp_t   core0_rsp_o,

   // Core 1 data memory
   input  logic        core1_req_valid_i,
   input  dmem_req_t   core1_req_i,
   output logic        core1_req_ack_o,
   output dmem_rsp_t   core1_rsp_o,

   // External bus
   output logic        xbus_req_valid_o,
   output dmem_req_t   xbus_req_o,
   input  logic        xbus_rsp_valid_i,
   input  dmem_rsp_t   xbus_rsp_i,

   // Timer to both cores
   output logic [63:0] timer_val_o,
   output logic        timer_irq_o
);

   // ---------------------------------------------------------------------
   // Internal links
   // ---------------------------------------------------------------------
   port_req_t port0_req;                   // Port 0 toward arbiter
   port_req_t port1_req;
   logic      port0_grant;
   logic      port1_grant;
   dmem_rsp_t port0_rsp;
   dmem_rsp_t port1_rsp;
   logic      tmr_req_valid;               // Arbiter to timer
   dmem_req_t tmr_req;
   dmem_rsp_t tmr_rsp;

   dmem_core_port u_port0 (
      .core_clk_i       (core_clk_i        ),
      .arst_n_i         (arst_n_i          ),
      .core_req_valid_i (core0_req_valid_i ),
      .core_req_i       (core0_req_i       ),
      .core_req_ack_o   (core0_req_ack_o   ),
      .core_rsp_o       (core0_rsp_o       ),
      .arb_req_o        (port0_req         ),
      .arb_grant_i      (port0_grant       ),
      .arb_rsp_i        (port0_rsp         )
   );

   dmem_core_port u_port1 (
      .core_clk_i       (core_clk_i        ),
      .arst_n_i         (arst_n_i          ),
      .core_req_valid_i (core1_req_valid_i ),
      .core_req_i       (core1_req_i       ),
      .core_req_ack_o   (core1_req_ack_o   ),
      .core_rsp_o       (core1_rsp_o       ),
      .arb_req_o        (port1_req         ),
      .arb_grant_i      (port1_grant       ),
      .arb_rsp_i        (port1_rsp         )
   );

   dmem_arbiter u_arbiter (
      .core_clk_i       (core_clk_i        ),
      .arst_n_i         (arst_n_i          ),
      .port0_req_i      (port0_req         ),
      .port1_req_i      (port1_req         ),
      .port0_grant_o    (port0_grant       ),
      .port1_grant_o    (port1_grant       ),
      .port0_rsp_o      (port0_rsp         ),
      .port1_rsp_o      (port1_rsp         ),
      .tmr_req_valid_o  (tmr_req_valid     ),
      .tmr_req_o        (tmr_req           ),
      .tmr_rsp_i        (tmr_rsp           ),
      .xbus_req_valid_o (xbus_req_valid_o  ),   // Straight to the pins
      .xbus_req_o       (xbus_req_o        ),
      .xbus_rsp_valid_i (xbus_rsp_valid_i  ),
      .xbus_rsp_i       (xbus_rsp_i        )
   );

   dmem_timer u_timer (
      .core_clk_i       (core_clk_i        ),
      .arst_n_i         (arst_n_i          ),
      .tmr_req_valid_i  (tmr_req_valid     ),
      .tmr_req_i        (tmr_req           ),
      .tmr_rsp_o        (tmr_rsp           ),
      .timer_val_o      (timer_val_o       ),
      .timer_irq_o      (timer_irq_o       )
   );

endmodule : dual_core_iconnect

`default_nettype wire

// File: verilog/dmem_timer.sv
// Memory-mapped machine timer with mtime, mtimecmp and compare interrupt on the core clock
`timescale 1ns/1ps
`default_nettype none

module dmem_timer import iconnect_pkg::*; (
   input  logic        core_clk_i,
   input  logic        arst_n_i,

   // Register access from the arbiter
   input  logic        tmr_req_valid_i,
   input  dmem_req_t   tmr_req_i,
   output dmem_rsp_t   tmr_rsp_o,          // Registered answer

   output logic [63:0] timer_val_o,        // Current mtime
   output logic        timer_irq_o
);

   logic                   enable_q;
   logic [63:0]            mtime_q;
   logic [63:0]            mtimecmp_q;
   dmem_resp_e             resp_q;
   logic [DMEM_DWIDTH-1:0] rdata_q;
   logic [5:0]             idx;            // Register index
   logic                   idx_ok;
   logic                   acc_ok;         // Legal word access
   logic                   wr_en;
   logic [DMEM_DWIDTH-1:0] reg_rd;
   logic [DMEM_DWIDTH-1:0] wdata;

   assign idx   = tmr_req_i.addr.tmr.reg_idx;
   assign wdata = tmr_req_i.wdata;

   // ---------------------------------------------------------------------
   // Decode and read mux
   // ---------------------------------------------------------------------
   always_comb begin
      idx_ok = 1'b1;
      case (idx)
         TMR_REG_CTRL:     reg_rd = {{(DMEM_DWIDTH-1){1'b0}}, enable_q};
         TMR_REG_MTIME_LO: reg_rd = mtime_q[31:0];
         TMR_REG_MTIME_HI: reg_rd = mtime_q[63:32];
         TMR_REG_CMP_LO:   reg_rd = mtimecmp_q[31:0];
         TMR_REG_CMP_HI:   reg_rd = mtimecmp_q[63:32];
         default: begin
            reg_rd = '0;
            idx_ok = 1'b0;                     // Hole in the map
         end
      endcase
   end

   // Word only and aligned
   assign acc_ok = idx_ok & (tmr_req_i.width == DMEM_WIDTH_WORD) &
                   (tmr_req_i.addr.tmr.byte_sel == 2'b00);
   assign wr_en  = tmr_req_valid_i & acc_ok & (tmr_req_i.cmd == DMEM_CMD_WR);

   // ---------------------------------------------------------------------
   // Registers
   // ---------------------------------------------------------------------
   always_ff @(posedge core_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         enable_q   <= 1'b0;
         mtime_q    <= '0;
         mtimecmp_q <= '1;                     // No compare hit out of reset
         resp_q     <= DMEM_RESP_NOTRDY;
      end else begin
         if (enable_q) begin
            mtime_q <= mtime_q + 64'd1;        // Counts core clocks
         end
         if (wr_en) begin
            case (idx)
               TMR_REG_CTRL:     enable_q   <= wdata[0];
               TMR_REG_MTIME_LO: mtime_q    <= {mtime_q[63:32], wdata};
               TMR_REG_MTIME_HI: mtime_q    <= {wdata, mtime_q[31:0]};
               TMR_REG_CMP_LO:   mtimecmp_q <= {mtimecmp_q[63:32], wdata};
               TMR_REG_CMP_HI:   mtimecmp_q <= {wdata, mtimecmp_q[31:0]};
               default: ;
            endcase
         end
         if (!tmr_req_valid_i) begin
            resp_q <= DMEM_RESP_NOTRDY;
         end else begin
            resp_q <= acc_ok ? DMEM_RESP_RDY_OK : DMEM_RESP_RDY_ER;
         end
      end
   end

   // Read data captured with the request
   always_ff @(posedge core_clk_i) begin
      if (tmr_req_valid_i) begin
         rdata_q <= acc_ok ? reg_rd : '0;
      end
   end

   assign tmr_rsp_o   = '{resp: resp_q, rdata: rdata_q};
   assign timer_val_o = mtime_q;
   assign timer_irq_o = enable_q & (mtime_q >= mtimecmp_q);   // Level until cmp moves

endmodule : dmem_timer

`default_nettype wire

// File: verilog/dmem_arbiter.sv
// Round-robin arbiter between two core ports with bus credits and in-order response routing
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter import iconnect_pkg::*; (
   input  logic      core_clk_i,
   input  logic      arst_n_i,

   // Core ports
   input  port_req_t port0_req_i,
   input  port_req_t port1_req_i,
   output logic      port0_grant_o,
   output logic      port1_grant_o,
   output dmem_rsp_t port0_rsp_o,
   output dmem_rsp_t port1_rsp_o,

   // Machine timer
   output logic      tmr_req_valid_o,
   output dmem_req_t tmr_req_o,
   input  dmem_rsp_t tmr_rsp_i,           // One cycle after the request

   // External bus, credit based
   output logic      xbus_req_valid_o,
   output dmem_req_t xbus_req_o,
   input  logic      xbus_rsp_valid_i,    // Also returns one credit
   input  dmem_rsp_t xbus_rsp_i
);

   port_req_t             req_a [2];
   dmem_rsp_t             rsp_a [2];
   logic [1:0]            elig;             // Valid and target can take it
   logic [1:0]            grant;
   logic                  sel;              // Winning port
   port_req_t             win;
   logic                  rr_last_q;        // Last port served
   logic                  tmr_send;
   logic                  xbus_send;
   logic                  tmr_port_q;       // Owner of the timer answer
   logic [XBUS_CNT_W-1:0] credit_q;
   logic                  tag_mem [XBUS_CREDITS];  // Port of each bus access in flight
   logic [XBUS_PTR_W-1:0] wr_ptr_q;
   logic [XBUS_PTR_W-1:0] rd_ptr_q;
   logic                  xbus_port;        // Tag at queue head

   function automatic logic [XBUS_PTR_W-1:0] ptr_inc(input logic [XBUS_PTR_W-1:0] p);
      return (p == XBUS_PTR_W'(XBUS_CREDITS - 1)) ? '0 : p + 1'b1;
   endfunction

   assign req_a[0] = port0_req_i;
   assign req_a[1] = port1_req_i;

   // ---------------------------------------------------------------------
   // Grant
   // ---------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         // Bus requests wait for a credit, timer never stalls
         elig[i] = req_a[i].valid &
                   ((req_a[i].target == TGT_TIMER) | (credit_q != '0));
      end
      grant[0] = elig[0] & (~elig[1] | rr_last_q);   // Tie goes to the other port
      grant[1] = elig[1] & (~elig[0] | ~rr_last_q);
   end

   assign sel           = grant[1];
   assign win           = req_a[sel];
   assign port0_grant_o = grant[0];
   assign port1_grant_o = grant[1];

   assign tmr_send  = (|grant) & (win.target == TGT_TIMER);
   assign xbus_send = (|grant) & (win.target == TGT_XBUS);

   assign tmr_req_valid_o  = tmr_send;
   assign tmr_req_o        = win.req;
   assign xbus_req_valid_o = xbus_send;
   assign xbus_req_o       = win.req;

   // ---------------------------------------------------------------------
   // Round-robin state, credits and tag queue pointers
   // ---------------------------------------------------------------------
   always_ff @(posedge core_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rr_last_q  <= 1'b1;                   // Port 0 wins the first tie
         tmr_port_q <= 1'b0;
         credit_q   <= XBUS_CNT_W'(XBUS_CREDITS);
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
      end else begin
         if (|grant) begin
            rr_last_q <= sel;
         end
         if (tmr_send) begin
            tmr_port_q <= sel;
         end
         // Spend on send, refund on answer
         credit_q <= credit_q - XBUS_CNT_W'(xbus_send) + XBUS_CNT_W'(xbus_rsp_valid_i);
         if (xbus_send) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (xbus_rsp_valid_i) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);     // Bus answers in order
         end
      end
   end

   always_ff @(posedge core_clk_i) begin
      if (xbus_send) begin
         tag_mem[wr_ptr_q] <= sel;
      end
   end

   assign xbus_port = tag_mem[rd_ptr_q];

   // ---------------------------------------------------------------------
   // Response routing
   // ---------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         rsp_a[i].resp  = DMEM_RESP_NOTRDY;
         rsp_a[i].rdata = xbus_rsp_i.rdata;
         if ((tmr_rsp_i.resp != DMEM_RESP_NOTRDY) && (tmr_port_q == 1'(i))) begin
            rsp_a[i] = tmr_rsp_i;
         end else if (xbus_rsp_valid_i && (xbus_port == 1'(i))) begin
            rsp_a[i] = xbus_rsp_i;
         end
      end
   end

   assign port0_rsp_o = rsp_a[0];
   assign port1_rsp_o = rsp_a[1];

endmodule : dmem_arbiter

`default_nettype wire

// File: verilog/dmem_core_port.sv
// Per-core data request port that decodes the target page and tracks the open access
`timescale 1ns/1ps
`default_nettype none

module dmem_core_port import iconnect_pkg::*; (
   input  logic      core_clk_i,          // Core clock
   input  logic      arst_n_i,            // Async reset, active low

   // Core side
   input  logic      core_req_valid_i,    // Held until ack
   input  dmem_req_t core_req_i,
   output logic      core_req_ack_o,
   output dmem_rsp_t core_rsp_o,

   // Arbiter side
   output port_req_t arb_req_o,
   input  logic      arb_grant_i,
   input  dmem_rsp_t arb_rsp_i
);

   logic         pending_q;               // Granted, answer not yet back
   logic         rsp_done;                // Final code seen this cycle
   dmem_target_e target;

   // ---------------------------------------------------------------------
   // Target decode and offer
   // ---------------------------------------------------------------------
   // Timer owns exactly one page, the rest goes out on the bus
   assign target = (core_req_i.addr.bus.page == TIMER_PAGE) ? TGT_TIMER : TGT_XBUS;

   assign arb_req_o = '{
      valid  : core_req_valid_i & ~pending_q,   // One access at a time
      target : target,
      req    : core_req_i
   };

   assign core_req_ack_o = arb_grant_i;       // Grant implies the offer was up

   // ---------------------------------------------------------------------
   // Pending tracking
   // ---------------------------------------------------------------------
   assign rsp_done = pending_q & (arb_rsp_i.resp != DMEM_RESP_NOTRDY);

   always_ff @(posedge core_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pending_q <= 1'b0;
      end else if (arb_grant_i) begin
         pending_q <= 1'b1;                    // Access launched
      end else if (rsp_done) begin
         pending_q <= 1'b0;
      end
   end

   // Answer only reaches the core while its own access is open
   assign core_rsp_o = '{
      resp  : rsp_done ? arb_rsp_i.resp : DMEM_RESP_NOTRDY,
      rdata : arb_rsp_i.rdata
   };

endmodule : dmem_core_port

`default_nettype wire

// File: verilog/iconnect_pkg.sv
// Shared widths, address map, response codes and request types, imported by every block
`default_nettype none

package iconnect_pkg;

   // ---------------------------------------------------------------------
   // Widths and address map
   // ---------------------------------------------------------------------
   localparam int DMEM_AWIDTH  = 32;              // Byte address
   localparam int DMEM_DWIDTH  = 32;              // Data word
   localparam int XBUS_CREDITS = 2;               // Requests in flight on the bus
   localparam int XBUS_CNT_W   = $clog2(XBUS_CREDITS + 1);
   localparam int XBUS_PTR_W   = (XBUS_CREDITS > 1) ? $clog2(XBUS_CREDITS) : 1;

   // Page that selects the machine timer
   localparam logic [DMEM_AWIDTH-9:0] TIMER_PAGE = 24'hF0_0000;

   // Timer register index within the page
   localparam logic [5:0] TMR_REG_CTRL     = 6'd0;  // Bit 0 enables counting
   localparam logic [5:0] TMR_REG_MTIME_LO = 6'd1;
   localparam logic [5:0] TMR_REG_MTIME_HI = 6'd2;
   localparam logic [5:0] TMR_REG_CMP_LO   = 6'd3;
   localparam logic [5:0] TMR_REG_CMP_HI   = 6'd4;

   // ---------------------------------------------------------------------
   // Encodings
   // ---------------------------------------------------------------------
   typedef enum logic {
      DMEM_CMD_RD = 1'b0,
      DMEM_CMD_WR = 1'b1
   } dmem_cmd_e;

   typedef enum logic [1:0] {
      DMEM_WIDTH_BYTE  = 2'b00,
      DMEM_WIDTH_HWORD = 2'b01,
      DMEM_WIDTH_WORD  = 2'b10
   } dmem_width_e;

   typedef enum logic [1:0] {
      DMEM_RESP_NOTRDY = 2'b00,                   // Still waiting
      DMEM_RESP_RDY_OK = 2'b01,
      DMEM_RESP_RDY_ER = 2'b10
   } dmem_resp_e;

   typedef enum logic {
      TGT_TIMER = 1'b0,
      TGT_XBUS  = 1'b1
   } dmem_target_e;

   // ---------------------------------------------------------------------
   // Address views and bundles
   // ---------------------------------------------------------------------
   typedef struct packed {
      logic [DMEM_AWIDTH-9:0] page;
      logic [7:0]             offset;
   } dmem_bus_addr_t;                             // Router view

   typedef struct packed {
      logic [DMEM_AWIDTH-9:0] page;
      logic [5:0]             reg_idx;
      logic [1:0]             byte_sel;
   } dmem_tmr_addr_t;                             // Timer register view

   typedef union packed {
      dmem_bus_addr_t bus;
      dmem_tmr_addr_t tmr;
   } dmem_addr_u;

   typedef struct packed {
      dmem_cmd_e              cmd;
      dmem_width_e            width;
      dmem_addr_u             addr;
      logic [DMEM_DWIDTH-1:0] wdata;
   } dmem_req_t;

   typedef struct packed {
      dmem_resp_e             resp;
      logic [DMEM_DWIDTH-1:0] rdata;
   } dmem_rsp_t;

   // Core port toward the arbiter
   typedef struct packed {
      logic         valid;
      dmem_target_e target;
      dmem_req_t    req;
   } port_req_t;

endpackage : iconnect_pkg

`default_nettype wire
